// File: verilog.f
common/arbPkg.sv
src/requestFsm.sv
src/cmdFifo.sv
src/busIssue.sv
src/readReturn.sv
src/memArbiterTop.sv
bench/memArbiter_asserts.sv
bench/memArbiterTb.sv

// File: Bender.yml
package:
  name: mem_arbiter

sources:
  - files:
      - common/arbPkg.sv
      - src/requestFsm.sv
      - src/cmdFifo.sv
      - src/busIssue.sv
      - src/readReturn.sv
      - src/memArbiterTop.sv
  - target: test
    files:
      - bench/memArbiter_asserts.sv
      - bench/memArbiterTb.sv

// File: bench/memArbiterTb.sv
`timescale 1ns/100ps

module memArbiterTb;
	import arbPkg::*;

	localparam int NumTests   = 300;    // Bus commands in the random phase
	localparam int HalfPeriod = 20;
	localparam int ClkPeriod  = 2 * HalfPeriod;

	logic gpuClk = 1'b0;
	logic i_rstN, i_texReqL, i_texReqR, i_clutReq, i_busy, i_dataInValid;
	logic o_fifoFull, o_fifoComplete, o_busy, o_texCompleteL, o_texCompleteR, o_texWrite;
	logic o_clutComplete, o_clutWrite, o_command, o_write;
	gpuCmd_t    i_memCmd;
	texAdr_t    i_texAdrL, i_texAdrR, o_texWriteAdr;
	memAdr_t    i_clutAdr, o_adr;
	texWord_t   o_texData;
	clutIdx_t   o_clutIndex;
	clutWord_t  o_clutData;
	cmdSize_t   o_commandSize;
	subAdr_t    o_subadr;
	blockMask_t o_writeMask;
	block_t     i_dataIn, o_dataOut;

	typedef struct packed {
		memOp_t     op;
		memAdr_t    adr;
		subAdr_t    sub;
		cmdSize_t   size;
		block_t     data;
		blockMask_t mask;
	} busCmd_t;

	// --------------------
	// Reference model state
	busCmd_t     expQ[$];           // Accepted, not yet on the bus
	busCmd_t     newCmd;
	logic        newValid;
	arbState_t   modelState, newState;
	texAdr_t     savedTexAdr;
	logic        reqL, reqR, reqClut;   // Requester levels
	texAdr_t     adrL, adrR;
	memAdr_t     adrClut;
	block_t      retData;           // Last block returned by memory
	int          respWait;          // Cycles until the read answer
	int          deliverLeft;
	clutIdx_t    deliverIdx;
	logic        genOn;
	logic [31:0] lfsr;
	int          errors, checks, issued;

	memArbiterTop memArbiterTop_inst (.*);

	bind memArbiterTop memArbiter_asserts memArbiterAsserts_inst (
		.gpuClk (gpuClk), .i_rstN (i_rstN), .i_command (o_command), .i_ddrBusy (i_busy),
		.i_texCompleteL (o_texCompleteL), .i_texCompleteR (o_texCompleteR),
		.i_clutWrite (o_clutWrite), .i_clutIndex (o_clutIndex),
		.i_clutComplete (o_clutComplete), .i_fifoFull (o_fifoFull), .i_arbBusy (o_busy)
	);

	always #(HalfPeriod) gpuClk = ~gpuClk;

	// 32 bit Fibonacci LFSR, taps 32 22 2 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] randBits(input int n);
		logic [31:0] val;
		int          b;
		val = '0;
		for (b = 0; b < n; b++) begin
			lfsr = lfsrNext(lfsr);
			val  = {val[30:0], lfsr[0]};    // One step per bit
		end
		return val;
	endfunction

	function automatic logic drained();
		return (expQ.size() == 0) && (modelState == Idle) && (deliverLeft == 0) &&
			(respWait == 0) && !reqL && !reqR && !reqClut;
	endfunction

	// --------------------
	// Compare tasks
	task automatic noteMismatch(input string msg);
		errors++;
		$display("mismatch at %0t ns: %s", $time, msg);
	endtask

	task automatic checkFlag(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) noteMismatch($sformatf("%s is %b, expected %b", name, got, exp));
	endtask

	task automatic checkBusCmd(input memOp_t op, input memAdr_t adr, input subAdr_t sub,
			input cmdSize_t size, input block_t data, input blockMask_t mask);
		checks++;
		if (o_write !== op[0]) noteMismatch($sformatf("o_write %b, expected %b", o_write, op[0]));
		if (o_adr !== adr) noteMismatch($sformatf("o_adr %h, expected %h", o_adr, adr));
		if (o_subadr !== sub) noteMismatch($sformatf("o_subadr %h, expected %h", o_subadr, sub));
		if (o_commandSize !== size)
			noteMismatch($sformatf("o_commandSize %h, expected %h", o_commandSize, size));
		if (op[0]) begin    // Payload only matters for writes
			if (o_dataOut !== data)
				noteMismatch($sformatf("o_dataOut %h, expected %h", o_dataOut, data));
			if (o_writeMask !== mask)
				noteMismatch($sformatf("o_writeMask %h, expected %h", o_writeMask, mask));
		end
	endtask

	task automatic checkTex(input texAdr_t adr, input texWord_t data);
		checks++;
		if (o_texWriteAdr !== adr)
			noteMismatch($sformatf("o_texWriteAdr %h, expected %h", o_texWriteAdr, adr));
		if (o_texData !== data) noteMismatch($sformatf("o_texData %h, expected %h", o_texData, data));
	endtask

	task automatic checkClut(input clutIdx_t idx, input clutWord_t data);
		checks++;
		if (o_clutIndex !== idx)
			noteMismatch($sformatf("o_clutIndex %0d, expected %0d", o_clutIndex, idx));
		if (o_clutData !== data)
			noteMismatch($sformatf("o_clutData %h, expected %h", o_clutData, data));
	endtask

	// --------------------
	// Stimulus, memory responder and acceptance prediction
	task automatic driveInputs();
		logic [1:0] kind;
		logic       full;
		busCmd_t    cmd;
		int         w;
		i_busy        = randBits(1);
		i_dataInValid = 1'b0;
		if (respWait > 0) begin
			respWait--;
			if (respWait == 0) begin
				i_dataInValid = 1'b1;
				for (w = 0; w < ClutWords; w++) i_dataIn[w*32 +: 32] = randBits(32);
			end
		end
		if (genOn) begin
			if (!reqL && randBits(3) == 0) begin
				reqL = 1'b1;
				adrL = texAdr_t'(randBits(17));
			end
			if (!reqR && randBits(3) == 0) begin
				reqR = 1'b1;
				adrR = texAdr_t'(randBits(17));
			end
			if (!reqClut && randBits(3) == 0) begin
				reqClut = 1'b1;
				adrClut = memAdr_t'(randBits(15));
			end
		end
		i_texReqL = reqL;
		i_texAdrL = adrL;
		i_texReqR = reqR;
		i_texAdrR = adrR;
		i_clutReq = reqClut;
		i_clutAdr = adrClut;
		full      = (expQ.size() == CmdFifoDepth);
		i_memCmd  = '0;
		if (genOn && !full && modelState == Idle) begin    // GPU only talks when not busy
			i_memCmd[55:24] = randBits(32);
			i_memCmd[23:3]  = 21'(randBits(21));
			kind            = randBits(2);
			case (kind)
				2'd1:    i_memCmd[2:0] = GpuCmdPixel;
				2'd2:    i_memCmd[2:0] = GpuCmdFill;
				2'd3:    i_memCmd[2:0] = 3'(3 + randBits(2)); // Ignored codes
				default: i_memCmd[2:0] = 3'd0;
			endcase
		end
		newValid = 1'b0;
		newState = modelState;
		if (!full && modelState == Idle) begin
			cmd      = '0;
			newValid = 1'b1;
			if (i_memCmd[2:0] == GpuCmdPixel) begin
				cmd.op         = OpWritePixel;
				cmd.adr        = i_memCmd[21:7];
				cmd.sub        = i_memCmd[6:4];
				cmd.size       = Size4;
				cmd.data[31:0] = i_memCmd[55:24];
				cmd.mask[1:0]  = i_memCmd[23:22];
			end else if (i_memCmd[2:0] == GpuCmdFill) begin
				cmd.op   = OpWriteBlock;
				cmd.adr  = i_memCmd[21:7];
				cmd.size = Size32;
				cmd.data = {16{i_memCmd[55:40]}};
				cmd.mask = '1;
			end else if (reqClut) begin
				cmd.op   = OpReadBlock;
				cmd.adr  = adrClut;
				cmd.size = Size32;
				newState = ReadClut;
			end else if (reqL || reqR) begin
				savedTexAdr = reqL ? adrL : adrR;  // L before R
				cmd.op   = OpRead8;
				cmd.adr  = savedTexAdr[16:2];
				cmd.sub  = {savedTexAdr[1:0], 1'b0};
				cmd.size = Size8;
				newState = reqL ? ReadTexL : ReadTexR;
			end else begin
				newValid = 1'b0;
			end
			newCmd = cmd;
		end
	endtask

	// Outputs are stable at the falling edge
	task automatic checkOutputs();
		logic    expCmd, expTex, expClut;
		busCmd_t cmd;
		checkFlag("o_fifoFull", o_fifoFull, expQ.size() == CmdFifoDepth);
		checkFlag("o_busy", o_busy, (expQ.size() == CmdFifoDepth) || (modelState != Idle));
		checkFlag("o_fifoComplete", o_fifoComplete, (expQ.size() == 0) && (modelState == Idle));
		expCmd = (expQ.size() != 0) && !i_busy;
		checkFlag("o_command", o_command, expCmd);
		if (expCmd && o_command) begin
			cmd = expQ.pop_front();     // Strict order, nothing dropped
			checkBusCmd(cmd.op, cmd.adr, cmd.sub, cmd.size, cmd.data, cmd.mask);
			issued++;
			if (!cmd.op[0]) respWait = 1 + (randBits(3) % 6);
		end
		expTex  = (deliverLeft > 0) && (modelState == ReadTexL || modelState == ReadTexR);
		expClut = (deliverLeft > 0) && (modelState == ReadClut);
		checkFlag("o_texWrite", o_texWrite, expTex);
		checkFlag("o_texCompleteL", o_texCompleteL, expTex && modelState == ReadTexL);
		checkFlag("o_texCompleteR", o_texCompleteR, expTex && modelState == ReadTexR);
		checkFlag("o_clutWrite", o_clutWrite, expClut);
		checkFlag("o_clutComplete", o_clutComplete, expClut && deliverLeft == 1);
		if (expTex && o_texWrite) checkTex(savedTexAdr, retData[63:0]);
		if (expClut && o_clutWrite) checkClut(deliverIdx, retData[deliverIdx*32 +: 32]);
		if (deliverLeft > 0) begin
			deliverLeft--;
			deliverIdx++;
			if (deliverLeft == 0) begin     // Completion seen, requester lets go
				case (modelState)
					ReadTexL: reqL    = 1'b0;
					ReadTexR: reqR    = 1'b0;
					ReadClut: reqClut = 1'b0;
					default:  ;
				endcase
				modelState = Idle;
			end
		end
		if (i_dataInValid) begin
			retData     = i_dataIn;
			deliverLeft = (modelState == ReadClut) ? ClutWords : 1;
			deliverIdx  = '0;
		end
		if (newValid) begin
			expQ.push_back(newCmd);
			modelState = newState;
		end
	endtask

	task automatic stepCycle();
		@(posedge gpuClk);
		#2;
		driveInputs();
		@(negedge gpuClk);
		checkOutputs();
	endtask

	// --------------------
	// Main sequence
	initial begin
		lfsr          = 32'h7118_b5d7;
		i_rstN        = 1'b0;
		i_memCmd      = '0;
		i_texReqL     = 1'b0;
		i_texReqR     = 1'b0;
		i_texAdrL     = '0;
		i_texAdrR     = '0;
		i_clutReq     = 1'b0;
		i_clutAdr     = '0;
		i_busy        = 1'b0;
		i_dataIn      = '0;
		i_dataInValid = 1'b0;
		{reqL, reqR, reqClut, genOn, newValid} = '0;
		{adrL, adrR, adrClut, savedTexAdr, retData} = '0;
		modelState  = Idle;
		deliverIdx  = '0;
		respWait    = 0;
		deliverLeft = 0;
		errors      = 0;
		checks      = 0;
		issued      = 0;
		repeat (16) @(posedge gpuClk);
		#2;
		i_rstN = 1'b1;
		@(negedge gpuClk);
		checkOutputs();     // Idle state straight out of reset
		genOn = 1'b1;
		while (issued < NumTests) stepCycle();
		genOn = 1'b0;
		while (!drained()) stepCycle();
		repeat (2) stepCycle();
		checkFlag("o_fifoComplete after drain", o_fifoComplete, 1'b1);
		checkFlag("o_busy after drain", o_busy, 1'b0);
		$display("checks %0d, errors %0d, bus commands %0d", checks, errors, issued);
		if (errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

	// Watchdog, 40 cycles per test
	initial begin
		#(NumTests * 40 * ClkPeriod);
		$display("timeout: the run did not finish after %0d cycles", NumTests * 40);
		$display(">>> FAIL");
		$finish;
	end

endmodule

// File: bench/memArbiter_asserts.sv
`timescale 1ns/100ps

module memArbiter_asserts (
	input logic             gpuClk,
	input logic             i_rstN,
	input logic             i_command,
	input logic             i_ddrBusy,
	input logic             i_texCompleteL,
	input logic             i_texCompleteR,
	input logic             i_clutWrite,
	input arbPkg::clutIdx_t i_clutIndex,
	input logic             i_clutComplete,
	input logic             i_fifoFull,
	input logic             i_arbBusy
);
	import arbPkg::*;

	// --------------------
	// DDR port rules
	// A stall holds a full FIFO as it is
	assert property (@(posedge gpuClk) disable iff (!i_rstN)
		(i_fifoFull && i_ddrBusy) |=> i_fifoFull)
		else $error("FIFO drained while memory busy");

	// The read was the last word queued, nothing left to issue
	assert property (@(posedge gpuClk) disable iff (!i_rstN)
		(i_texCompleteL || i_texCompleteR || i_clutWrite) |-> !i_command)
		else $error("bus command during read delivery");

	assert property (@(posedge gpuClk) disable iff (!i_rstN)
		(i_texCompleteL || i_texCompleteR || i_clutComplete) |=> !i_arbBusy)
		else $error("arbiter still busy after read completion");   // Back to Idle

	// --------------------
	// CLUT slices run 0..7 back to back
	assert property (@(posedge gpuClk) disable iff (!i_rstN)
		$rose(i_clutWrite) |-> (i_clutIndex == '0))
		else $error("CLUT burst not starting at index 0");

	assert property (@(posedge gpuClk) disable iff (!i_rstN)
		(i_clutWrite && !i_clutComplete) |=>
			i_clutWrite && (i_clutIndex == $past(i_clutIndex) + 1'b1))
		else $error("CLUT slice sequence broken");

	assert property (@(posedge gpuClk) disable iff (!i_rstN)
		i_clutComplete |=> !i_clutWrite)
		else $error("CLUT burst ran past the last slice");

endmodule

// File: src/memArbiterTop.sv
`timescale 1ns/100ps

module memArbiterTop (
	input  logic               gpuClk,
	input  logic               i_rstN,
	// GPU command side
	input  arbPkg::gpuCmd_t    i_memCmd,
	output logic               o_fifoFull,
	output logic               o_fifoComplete,
	output logic               o_busy,
	// Texture cache
	input  logic               i_texReqL,
	input  arbPkg::texAdr_t    i_texAdrL,
	output logic               o_texCompleteL,
	input  logic               i_texReqR,
	input  arbPkg::texAdr_t    i_texAdrR,
	output logic               o_texCompleteR,
	output arbPkg::texAdr_t    o_texWriteAdr,
	output logic               o_texWrite,
	output arbPkg::texWord_t   o_texData,
	// CLUT cache
	input  logic               i_clutReq,
	input  arbPkg::memAdr_t    i_clutAdr,
	output logic               o_clutComplete,
	output logic               o_clutWrite,
	output arbPkg::clutIdx_t   o_clutIndex,
	output arbPkg::clutWord_t  o_clutData,
	// DDR port
	output logic               o_command,
	input  logic               i_busy,
	output arbPkg::cmdSize_t   o_commandSize,
	output logic               o_write,
	output arbPkg::memAdr_t    o_adr,
	output arbPkg::subAdr_t    o_subadr,
	output arbPkg::blockMask_t o_writeMask,
	input  arbPkg::block_t     i_dataIn,
	input  logic               i_dataInValid,
	output arbPkg::block_t     o_dataOut
);
	import arbPkg::*;

	cmdWord_t  cmdWord;     // FSM to FIFO
	logic      cmdWrite;
	cmdWord_t  headWord;    // FIFO to bus
	logic      fifoEmpty;
	logic      pop;
	arbState_t state;
	texAdr_t   texAdr;
	logic      readDone;

	// --------------------
	// Request side
	requestFsm requestFsm_inst (
		.gpuClk         (gpuClk),
		.i_rstN         (i_rstN),
		.i_memCmd       (i_memCmd),
		.i_clutReq      (i_clutReq),
		.i_clutAdr      (i_clutAdr),
		.i_texReqL      (i_texReqL),
		.i_texReqR      (i_texReqR),
		.i_texAdrL      (i_texAdrL),
		.i_texAdrR      (i_texAdrR),
		.i_fifoFull     (o_fifoFull),
		.i_fifoEmpty    (fifoEmpty),
		.i_readDone     (readDone),
		.o_cmdWord      (cmdWord),
		.o_cmdWrite     (cmdWrite),
		.o_state        (state),
		.o_texAdr       (texAdr),
		.o_busy         (o_busy),
		.o_fifoComplete (o_fifoComplete)
	);

	cmdFifo #(
		.DEPTH (CmdFifoDepth)
	) cmdFifo_inst (
		.gpuClk   (gpuClk),
		.i_rstN   (i_rstN),
		.i_wrData (cmdWord),
		.i_wrEn   (cmdWrite),
		.i_rdEn   (pop),
		.o_rdData (headWord),
		.o_full   (o_fifoFull),
		.o_empty  (fifoEmpty)
	);

	// --------------------
	// DDR side
	busIssue busIssue_inst (
		.i_head        (headWord),
		.i_empty       (fifoEmpty),
		.i_busy        (i_busy),
		.o_pop         (pop),
		.o_command     (o_command),
		.o_write       (o_write),
		.o_commandSize (o_commandSize),
		.o_adr         (o_adr),
		.o_subadr      (o_subadr),
		.o_dataOut     (o_dataOut),
		.o_writeMask   (o_writeMask)
	);

	readReturn readReturn_inst (
		.gpuClk         (gpuClk),
		.i_rstN         (i_rstN),
		.i_state        (state),
		.i_texAdr       (texAdr),
		.i_dataIn       (i_dataIn),
		.i_dataInValid  (i_dataInValid),
		.o_texWrite     (o_texWrite),
		.o_texWriteAdr  (o_texWriteAdr),
		.o_texData      (o_texData),
		.o_texCompleteL (o_texCompleteL),
		.o_texCompleteR (o_texCompleteR),
		.o_clutWrite    (o_clutWrite),
		.o_clutIndex    (o_clutIndex),
		.o_clutData     (o_clutData),
		.o_clutComplete (o_clutComplete),
		.o_readDone     (readDone)
	);

endmodule

// File: src/readReturn.sv
`timescale 1ns/100ps

module readReturn (
	input  logic              gpuClk,
	input  logic              i_rstN,
	input  arbPkg::arbState_t i_state,
	input  arbPkg::texAdr_t   i_texAdr,
	input  arbPkg::block_t    i_dataIn,
	input  logic              i_dataInValid,
	output logic              o_texWrite,
	output arbPkg::texAdr_t   o_texWriteAdr,
	output arbPkg::texWord_t  o_texData,
	output logic              o_texCompleteL,
	output logic              o_texCompleteR,
	output logic              o_clutWrite,
	output arbPkg::clutIdx_t  o_clutIndex,
	output arbPkg::clutWord_t o_clutData,
	output logic              o_clutComplete,
	output logic              o_readDone
);
	import arbPkg::*;

	block_t   resData;      // Returned block
	logic     resValid;
	clutIdx_t clutIdx;      // Slice being delivered
	logic     isTex;
	logic     lastSlice;

	assign isTex     = (i_state == ReadTexL) || (i_state == ReadTexR);
	assign lastSlice = (clutIdx == clutIdx_t'(ClutWords - 1));

	// Result register, payload only
	always_ff @(posedge gpuClk) begin
		if (i_dataInValid) begin
			resData <= i_dataIn;
		end
	end

	// --------------------
	// Valid flag and slice counter
	always_ff @(posedge gpuClk) begin
		if (!i_rstN) begin
			resValid <= 1'b0;
			clutIdx  <= '0;
		end else begin
			if (o_readDone) begin
				resValid <= 1'b0;   // Final delivery done
				clutIdx  <= '0;
			end else if (o_clutWrite) begin
				clutIdx <= clutIdx + 1'b1;
			end
			if (i_dataInValid) begin
				resValid <= 1'b1;
			end
		end
	end

	// Texture cache side, one 64 bit word
	assign o_texWrite     = resValid && isTex;
	assign o_texWriteAdr  = i_texAdr;
	assign o_texData      = resData[$bits(texWord_t)-1:0];
	assign o_texCompleteL = resValid && (i_state == ReadTexL);
	assign o_texCompleteR = resValid && (i_state == ReadTexR);

	// --------------------
	// CLUT side, eight slices
	assign o_clutWrite    = resValid && (i_state == ReadClut);
	assign o_clutIndex    = clutIdx;
	assign o_clutData     = resData[clutIdx * $bits(clutWord_t) +: $bits(clutWord_t)];
	assign o_clutComplete = o_clutWrite && lastSlice;   // With index 7

	assign o_readDone = o_texWrite || o_clutComplete;   // Releases the FSM

endmodule

// File: src/busIssue.sv
`timescale 1ns/100ps

module busIssue (
	input  arbPkg::cmdWord_t   i_head,
	input  logic               i_empty,
	input  logic               i_busy,
	output logic               o_pop,
	output logic               o_command,
	output logic               o_write,
	output arbPkg::cmdSize_t   o_commandSize,
	output arbPkg::memAdr_t    o_adr,
	output arbPkg::subAdr_t    o_subadr,
	output arbPkg::block_t     o_dataOut,
	output arbPkg::blockMask_t o_writeMask
);
	import arbPkg::*;

	memOp_t     op;
	blockMask_t headMask;
	logic       hasSub;     // 4 or 8 byte access

	assign op       = i_head[CmdOpLsb +: $bits(memOp_t)];
	assign headMask = i_head[CmdMaskLsb +: $bits(blockMask_t)];
	assign hasSub   = (op == OpRead8) || (op == OpWritePixel);

	// --------------------
	// Size from opcode
	always_comb begin
		case (op)
			OpRead8:      o_commandSize = Size8;
			OpWritePixel: o_commandSize = Size4;
			default:      o_commandSize = Size32;   // Block read and fill
		endcase
	end

	// Issue and pop in the same cycle
	assign o_pop     = !i_empty && !i_busy;
	assign o_command = o_pop;

	assign o_write   = op[0];
	assign o_adr     = i_head[CmdAdrLsb +: $bits(memAdr_t)];
	assign o_subadr  = hasSub ? i_head[CmdSubLsb +: $bits(subAdr_t)] : '0; // Zero for 32 byte
	assign o_dataOut = i_head[CmdDataLsb +: $bits(block_t)];

	// Small ops keep only the 2 bit pixel mask, sub-address bits stripped
	assign o_writeMask = hasSub ? {14'd0, headMask[1:0]} : headMask;

endmodule

// File: src/cmdFifo.sv
`timescale 1ns/100ps

module cmdFifo #(
	parameter int DEPTH = arbPkg::CmdFifoDepth
) (
	input  logic             gpuClk,
	input  logic             i_rstN,
	input  arbPkg::cmdWord_t i_wrData,
	input  logic             i_wrEn,
	input  logic             i_rdEn,
	output arbPkg::cmdWord_t o_rdData,
	output logic             o_full,
	output logic             o_empty
);
	import arbPkg::*;

	localparam int PtrW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CntW = $clog2(DEPTH + 1);

	cmdWord_t        mem [DEPTH];
	logic [PtrW-1:0] wrPtr;
	logic [PtrW-1:0] rdPtr;
	logic [CntW-1:0] count;   // Words held
	logic            doWr;
	logic            doRd;

	assign doWr = i_wrEn && !o_full;    // Overflow guard
	assign doRd = i_rdEn && !o_empty;

	// Storage
	always_ff @(posedge gpuClk) begin
		if (doWr) begin
			mem[wrPtr] <= i_wrData;
		end
	end

	// --------------------
	// Pointers and occupancy
	always_ff @(posedge gpuClk) begin
		if (!i_rstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (doWr) begin
				wrPtr <= (wrPtr == PtrW'(DEPTH - 1)) ? '0 : wrPtr + 1'b1;
			end
			if (doRd) begin
				rdPtr <= (rdPtr == PtrW'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
			end
			case ({doWr, doRd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;    // Both or none
			endcase
		end
	end

	assign o_rdData = mem[rdPtr];   // Head, no pop needed
	assign o_full   = (count == CntW'(DEPTH));
	assign o_empty  = (count == '0);

endmodule

// File: src/requestFsm.sv
`timescale 1ns/100ps

module requestFsm (
	input  logic              gpuClk,
	input  logic              i_rstN,
	input  arbPkg::gpuCmd_t   i_memCmd,
	input  logic              i_clutReq,
	input  arbPkg::memAdr_t   i_clutAdr,
	input  logic              i_texReqL,
	input  logic              i_texReqR,
	input  arbPkg::texAdr_t   i_texAdrL,
	input  arbPkg::texAdr_t   i_texAdrR,
	input  logic              i_fifoFull,
	input  logic              i_fifoEmpty,
	input  logic              i_readDone,
	output arbPkg::cmdWord_t  o_cmdWord,
	output logic              o_cmdWrite,
	output arbPkg::arbState_t o_state,
	output arbPkg::texAdr_t   o_texAdr,
	output logic              o_busy,
	output logic              o_fifoComplete
);
	import arbPkg::*;

	arbState_t state;
	arbState_t nextState;
	texAdr_t   texAdrSel;     // L wins over R
	texAdr_t   texAdrSaved;   // Where the returned line goes
	logic      saveTexAdr;
	logic      gpuPixel;
	logic      gpuFill;

	assign gpuPixel  = (i_memCmd[2:0] == GpuCmdPixel);
	assign gpuFill   = (i_memCmd[2:0] == GpuCmdFill);
	assign texAdrSel = i_texReqL ? i_texAdrL : i_texAdrR;

	// --------------------
	// Pick a request and pack it
	always_comb begin
		o_cmdWord  = '0;    // Unused fields stay zero
		o_cmdWrite = 1'b0;
		nextState  = state;
		saveTexAdr = 1'b0;
		if (state == Idle) begin
			if (!i_fifoFull) begin
				if (gpuPixel) begin
					o_cmdWrite = 1'b1;
					o_cmdWord[CmdOpLsb +: $bits(memOp_t)]   = OpWritePixel;
					o_cmdWord[CmdAdrLsb +: $bits(memAdr_t)] = i_memCmd[21:7];
					o_cmdWord[CmdDataLsb +: 32]             = i_memCmd[55:24]; // Low word
					o_cmdWord[CmdMaskLsb +: 2]              = i_memCmd[23:22]; // Pixel mask
					o_cmdWord[CmdSubLsb +: $bits(subAdr_t)] = i_memCmd[6:4];
				end else if (gpuFill) begin
					o_cmdWrite = 1'b1;
					o_cmdWord[CmdOpLsb +: $bits(memOp_t)]     = OpWriteBlock;
					o_cmdWord[CmdAdrLsb +: $bits(memAdr_t)]   = i_memCmd[21:7];
					o_cmdWord[CmdDataLsb +: $bits(block_t)]   = {16{i_memCmd[55:40]}};
					o_cmdWord[CmdMaskLsb +: $bits(blockMask_t)] = '1; // Every pixel
				end else if (i_clutReq) begin
					// Whole block read, sliced on return
					o_cmdWrite = 1'b1;
					o_cmdWord[CmdOpLsb +: $bits(memOp_t)]   = OpReadBlock;
					o_cmdWord[CmdAdrLsb +: $bits(memAdr_t)] = i_clutAdr;
					nextState = ReadClut;
				end else if (i_texReqL || i_texReqR) begin
					o_cmdWrite = 1'b1;
					saveTexAdr = 1'b1;
					o_cmdWord[CmdOpLsb +: $bits(memOp_t)]   = OpRead8;
					o_cmdWord[CmdAdrLsb +: $bits(memAdr_t)] = texAdrSel[16:2];
					o_cmdWord[CmdSubLsb +: $bits(subAdr_t)] = {texAdrSel[1:0], 1'b0};
					nextState = i_texReqL ? ReadTexL : ReadTexR;
				end
			end
		end else if (i_readDone) begin
			nextState = Idle;   // Read delivered, free again
		end
	end

	always_ff @(posedge gpuClk) begin
		if (!i_rstN) begin
			state <= Idle;
		end else begin
			state <= nextState;
		end
	end

	always_ff @(posedge gpuClk) begin
		if (saveTexAdr) begin
			texAdrSaved <= texAdrSel;
		end
	end

	assign o_state        = state;
	assign o_texAdr       = texAdrSaved;
	assign o_busy         = i_fifoFull || (state != Idle);  // Stall GPU
	assign o_fifoComplete = (state == Idle) && i_fifoEmpty; // All work drained

endmodule

// File: common/arbPkg.sv
package arbPkg;

	// --------------------
	// Widths with a meaning
	typedef logic [55:0]  gpuCmd_t;     // GPU command word, code in [2:0]
	typedef logic [2:0]   memOp_t;      // Bit 0 = write
	typedef logic [14:0]  memAdr_t;     // 32768 blocks of 32 bytes
	typedef logic [2:0]   subAdr_t;     // 4 or 8 byte slot in a block
	typedef logic [1:0]   cmdSize_t;    // DDR access size
	typedef logic [255:0] block_t;      // One 32 byte block
	typedef logic [15:0]  blockMask_t;  // One bit per 16 bit pixel
	typedef logic [16:0]  texAdr_t;
	typedef logic [63:0]  texWord_t;
	typedef logic [31:0]  clutWord_t;
	typedef logic [2:0]   clutIdx_t;    // 0..7
	typedef logic [289:0] cmdWord_t;    // {mask, data, adr, op}

	// Outstanding read tracking
	typedef enum logic [1:0] {
		Idle,
		ReadTexL,
		ReadTexR,
		ReadClut
	} arbState_t;

	// --------------------
	// Command word opcodes
	localparam memOp_t OpReadBlock  = 3'd0;
	localparam memOp_t OpWriteBlock = 3'd1;
	localparam memOp_t OpRead8      = 3'd2;
	localparam memOp_t OpWritePixel = 3'd3;

	// GPU side command codes, anything else is dropped
	localparam logic [2:0] GpuCmdPixel = 3'd1;
	localparam logic [2:0] GpuCmdFill  = 3'd2;

	// DDR access sizes
	localparam cmdSize_t Size8  = 2'd0;
	localparam cmdSize_t Size32 = 2'd1;
	localparam cmdSize_t Size4  = 2'd2;

	// --------------------
	// Field positions inside cmdWord_t
	localparam int CmdOpLsb   = 0;
	localparam int CmdAdrLsb  = CmdOpLsb + $bits(memOp_t);    // 3
	localparam int CmdDataLsb = CmdAdrLsb + $bits(memAdr_t);  // 18
	localparam int CmdMaskLsb = CmdDataLsb + $bits(block_t);  // 274
	// Sub-address rides in mask bits 4..2 for 4/8 byte ops
	localparam int CmdSubLsb  = CmdMaskLsb + 2;

	localparam int CmdFifoDepth = 4;
	localparam int ClutWords    = 8;    // 32 bit slices per block

endpackage
